// File: all.f
fsync_pkg.sv
fsync_quad_if.sv
fsync_root_if.sv
fsync_cu_ports.sv
fsync_quad_node.sv
fsync_root_node.sv
fsync_net_4x4.sv
tb_clock_gen.sv
tb_fsync_net.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the barrier network testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fsync_net -f all.f -o sim_fsync

status=0
./obj_dir/sim_fsync > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
  echo "Simulation failed."
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -qF '*** TEST PASSED ***' sim.log; then
  echo "Simulation did not complete."
  exit 1
fi
echo "Simulation passed."

// File: tb_fsync_net.sv
// Testbench for the 4x4 barrier network.
// Stimulus tasks, cycle reference model and checking assertions.

`timescale 1ns/1ps

module tb_fsync_net;

  localparam int ID_WIDTH     = 4;
  localparam int N_CUS        = fsync_pkg::N_CUS;
  localparam int N_QUADS      = fsync_pkg::N_QUADS;
  localparam int CUS_PER_QUAD = fsync_pkg::CUS_PER_QUAD;
  localparam int LVL_WIDTH    = fsync_pkg::LVL_WIDTH;
  localparam int GRID_DIM     = fsync_pkg::GRID_DIM;
  localparam int QUAD_DIM     = fsync_pkg::QUAD_DIM;
  localparam int DRIVE_DELAY  = 5;   // After the rising edge.
  localparam int TIMEOUT      = 50;  // Cycles per wait loop.

  logic clk;
  logic reset;
  logic [N_CUS-1:0]                req_valid;
  logic [N_CUS-1:0][LVL_WIDTH-1:0] req_level;
  logic [N_CUS-1:0][ID_WIDTH-1:0]  req_id;
  logic [N_CUS-1:0]                req_ready;
  logic [N_CUS-1:0]                wake;
  logic [N_CUS-1:0]                wake_error;
  logic [N_CUS-1:0][LVL_WIDTH-1:0] wake_level;
  logic [N_CUS-1:0][ID_WIDTH-1:0]  wake_id;

  int    seed = 32'h749d;
  int    order [N_CUS];
  string test_name = "reset";

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) i_clock_gen (.clk_o(clk), .reset_o(reset));

  fsync_net_4x4 #(.ID_WIDTH(ID_WIDTH)) UUT (
    .clk_i(clk), .reset_i(reset),
    .req_valid_i(req_valid), .req_level_i(req_level), .req_id_i(req_id),
    .req_ready_o(req_ready), .wake_o(wake), .wake_error_o(wake_error),
    .wake_level_o(wake_level), .wake_id_o(wake_id)
  );

  // Row-major CU index of member m in quadrant q.
  function automatic int cu_of(int q, int m);
    return ((q / QUAD_DIM) * QUAD_DIM + m / QUAD_DIM) * GRID_DIM +
           (q % QUAD_DIM) * QUAD_DIM + m % QUAD_DIM;
  endfunction

  function automatic int quad_of(int cu);
    return ((cu / GRID_DIM) / QUAD_DIM) * QUAD_DIM + (cu % GRID_DIM) / QUAD_DIM;
  endfunction

  // ****************************************
  // Reference model
  // ****************************************

  logic [N_CUS-1:0]                exp_pend;
  logic [N_CUS-1:0]                exp_wake;
  logic [N_CUS-1:0]                exp_err;
  logic [N_CUS-1:0][LVL_WIDTH-1:0] exp_lvl;
  logic [N_CUS-1:0][ID_WIDTH-1:0]  exp_id;
  logic [N_QUADS-1:0][ID_WIDTH-1:0] up_id;
  logic [N_QUADS-1:0]              quad_busy;  // Fired or raised, not yet released.
  logic [N_QUADS-1:0]              quad_up;
  logic                            root_busy;
  int                              wake_cnt [N_CUS];  // Cycles left to a scheduled wake.
  logic                            err_due [N_CUS];

  always @(posedge clk) begin
    logic [N_CUS-1:0]    acc;
    logic                all_pend;
    logic                all_quad;
    logic                all_glob;
    logic                same_id;
    int                  c;
    if (reset) begin
      exp_pend  = '0;
      exp_wake  = '0;
      exp_err   = '0;
      quad_busy = '0;
      quad_up   = '0;
      root_busy = 1'b0;
      for (int i = 0; i < N_CUS; i++) wake_cnt[i] = 0;
    end else begin
      acc      = req_valid & ~exp_pend;  // Ready is high only when not pending.
      exp_wake = '0;
      exp_err  = '0;
      for (int i = 0; i < N_CUS; i++) begin
        if (wake_cnt[i] == 1) begin
          exp_wake[i] = 1'b1;
          exp_err[i]  = err_due[i];
          exp_pend[i] = 1'b0;
        end
        if (wake_cnt[i] > 0) wake_cnt[i] = wake_cnt[i] - 1;
      end
      for (int q = 0; q < N_QUADS; q++) begin
        if (exp_wake[cu_of(q, 0)]) begin
          quad_busy[q] = 1'b0;
          quad_up[q]   = 1'b0;
        end
      end
      if (&exp_wake) root_busy = 1'b0;
      for (int i = 0; i < N_CUS; i++) begin
        if (acc[i]) begin
          exp_pend[i] = 1'b1;
          exp_lvl[i]  = req_level[i];
          exp_id[i]   = req_id[i];
        end
      end
      // A quadrant barrier wakes 2 cycles after the last accept or raises level 2.
      for (int q = 0; q < N_QUADS; q++) begin
        all_pend = 1'b1;
        all_quad = 1'b1;
        all_glob = 1'b1;
        same_id  = 1'b1;
        for (int m = 0; m < CUS_PER_QUAD; m++) begin
          c = cu_of(q, m);
          all_pend &= exp_pend[c];
          all_quad &= (exp_lvl[c] == fsync_pkg::LVL_QUAD);
          all_glob &= (exp_lvl[c] == fsync_pkg::LVL_GLOBAL);
          same_id  &= (exp_id[c] == exp_id[cu_of(q, 0)]);
        end
        if (all_pend && !quad_busy[q]) begin
          quad_busy[q] = 1'b1;
          if (all_glob && same_id) begin
            quad_up[q] = 1'b1;
            up_id[q]   = exp_id[cu_of(q, 0)];
          end else begin
            for (int m = 0; m < CUS_PER_QUAD; m++) begin
              wake_cnt[cu_of(q, m)] = 2;
              err_due[cu_of(q, m)]  = !(all_quad && same_id);
            end
          end
        end
      end
      // A global barrier wakes all sixteen 3 cycles after the last accept.
      if (&quad_up && !root_busy) begin
        root_busy = 1'b1;
        same_id   = (up_id[1] == up_id[0]) && (up_id[2] == up_id[0]) && (up_id[3] == up_id[0]);
        for (int i = 0; i < N_CUS; i++) begin
          wake_cnt[i] = 3;
          err_due[i]  = !same_id;
        end
      end
    end
  end

  // ****************************************
  // Checks
  // ****************************************

  task automatic report_mismatch(string what, logic [63:0] expected, logic [63:0] actual);
    $display("CHECK FAILED test=%s signal=%s expected=%h actual=%h",
             test_name, what, expected, actual);
    $display("*** TEST FAILED ***");
    $fatal(1, "Output mismatch.");
  endtask

  task automatic stop_on_timeout(string what);
    $display("Timeout in test %s: %s", test_name, what);
    $display("*** TEST FAILED ***");
    $fatal(1, "Wait timed out.");
  endtask

  // Outputs are sampled mid-cycle, away from both clock and drive edges.
  wake_check: assert property (@(negedge clk) disable iff (reset) wake == exp_wake)
    else report_mismatch("wake_o", 64'(exp_wake), 64'(wake));
  error_check: assert property (@(negedge clk) disable iff (reset) wake_error == exp_err)
    else report_mismatch("wake_error_o", 64'(exp_err), 64'(wake_error));
  ready_check: assert property (@(negedge clk) disable iff (reset) req_ready == ~exp_pend)
    else report_mismatch("req_ready_o", 64'(~exp_pend), 64'(req_ready));
  ready_on_wake: assert property (@(negedge clk) disable iff (reset) (wake & ~req_ready) == '0)
    else report_mismatch("req_ready_o with wake_o", 64'(wake), 64'(wake & req_ready));

  for (genvar c = 0; c < N_CUS; c++) begin : gen_echo
    echo_check: assert property (@(negedge clk) disable iff (reset)
        !wake[c] || (wake_level[c] == exp_lvl[c] && wake_id[c] == exp_id[c]))
      else report_mismatch("wake_level_o/wake_id_o", 64'({exp_lvl[c], exp_id[c]}),
                           64'({wake_level[c], wake_id[c]}));
  end

  // ****************************************
  // Stimulus
  // ****************************************

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic idle_gap();
    repeat ($unsigned($random(seed)) % 3) next_cycle();
  endtask

  task automatic shuffle(int n);
    int j;
    int t;
    for (int i = n - 1; i > 0; i--) begin
      j        = int'($unsigned($random(seed)) % (i + 1));
      t        = order[i];
      order[i] = order[j];
      order[j] = t;
    end
  endtask

  // Returns just after the accepting edge; hold keeps valid raised.
  task automatic send_req(int cu, logic [LVL_WIDTH-1:0] lvl, logic [ID_WIDTH-1:0] id, bit hold);
    int waited;
    waited        = 0;
    req_valid[cu] = 1'b1;
    req_level[cu] = lvl;
    req_id[cu]    = id;
    while (!req_ready[cu] && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!req_ready[cu]) begin
      stop_on_timeout("request never accepted");
    end else begin
      next_cycle();
      if (!hold) req_valid[cu] = 1'b0;
    end
  endtask

  task automatic wait_wake(logic [N_CUS-1:0] mask);
    int waited;
    waited = 0;
    while ((wake & mask) != mask && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if ((wake & mask) != mask) begin
      stop_on_timeout("wake never arrived");
    end else begin
      repeat (3) next_cycle();
    end
  endtask

  task automatic run_quad(int q, logic [3:0][LVL_WIDTH-1:0] lvls, logic [3:0][ID_WIDTH-1:0] ids);
    logic [N_CUS-1:0] mask;
    mask = '0;
    for (int m = 0; m < 4; m++) begin
      order[m]            = m;
      mask[cu_of(q, m)] = 1'b1;
    end
    shuffle(4);
    for (int k = 0; k < 4; k++) begin
      send_req(cu_of(q, order[k]), lvls[order[k]], ids[order[k]], 1'b0);
      idle_gap();
    end
    wait_wake(mask);
  endtask

  task automatic run_global(logic [3:0][ID_WIDTH-1:0] quad_ids);
    for (int i = 0; i < N_CUS; i++) order[i] = i;
    shuffle(N_CUS);
    for (int k = 0; k < N_CUS; k++) begin
      send_req(order[k], fsync_pkg::LVL_GLOBAL, quad_ids[quad_of(order[k])], 1'b0);
      idle_gap();
    end
    wait_wake('1);
  endtask

  initial begin
    logic [ID_WIDTH-1:0] id;
    int                  waited;
    req_valid = '0;
    req_level = '0;
    req_id    = '0;
    waited    = 0;
    while (reset && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (reset) stop_on_timeout("reset never released");
    repeat (4) next_cycle();  // Idle outputs checked by the model.

    test_name = "quad_barrier";
    for (int q = 0; q < N_QUADS; q++) begin
      id = ID_WIDTH'($random(seed));
      run_quad(q, {4{fsync_pkg::LVL_QUAD}}, {4{id}});
    end

    test_name = "quad_mismatch";
    id = ID_WIDTH'($random(seed));
    run_quad(1, {4{fsync_pkg::LVL_QUAD}}, {id, id, id, id ^ 4'd1});
    run_quad(2, {fsync_pkg::LVL_QUAD, fsync_pkg::LVL_GLOBAL, fsync_pkg::LVL_QUAD,
                 fsync_pkg::LVL_QUAD}, {4{id}});
    run_quad(3, {fsync_pkg::LVL_QUAD, 2'd3, fsync_pkg::LVL_QUAD, fsync_pkg::LVL_QUAD}, {4{id}});

    test_name = "global_barrier";
    id = ID_WIDTH'($random(seed));
    run_global({4{id}});

    test_name = "global_mismatch";
    id = ID_WIDTH'($random(seed));
    run_global({id, id ^ 4'd5, id, id});

    test_name = "back_pressure";
    id = ID_WIDTH'($random(seed));
    send_req(cu_of(0, 0), fsync_pkg::LVL_QUAD, id, 1'b1);
    req_id[cu_of(0, 0)] = id ^ 4'd1;  // A second accept would show up in the echoed id.
    repeat (4) next_cycle();  // Valid held while pending.
    send_req(cu_of(0, 1), fsync_pkg::LVL_QUAD, id, 1'b0);
    send_req(cu_of(0, 2), fsync_pkg::LVL_QUAD, id, 1'b0);
    req_valid[cu_of(0, 0)] = 1'b0;
    send_req(cu_of(0, 3), fsync_pkg::LVL_QUAD, id, 1'b0);
    wait_wake(N_CUS'(1 << cu_of(0, 0)));

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule : tb_fsync_net

// File: tb_clock_gen.sv
// Testbench clock and reset generator.
// Free-running clock and a synchronous reset held for a few cycles.

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 reset_o = 1'b0;  // Released just after the last reset edge.
  end

endmodule : tb_clock_gen

// File: fsync_net_4x4.sv
// Top of the 4x4 barrier network.
// CU port block, four quadrant nodes and the root node, with plain CU ports.

`timescale 1ns/1ps

module fsync_net_4x4 #(
  parameter int unsigned ID_WIDTH = 4
) (
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,

  // CU requests.
  input  logic [fsync_pkg::N_CUS-1:0]                          req_valid_i,
  input  logic [fsync_pkg::N_CUS-1:0][fsync_pkg::LVL_WIDTH-1:0] req_level_i,
  input  logic [fsync_pkg::N_CUS-1:0][ID_WIDTH-1:0]            req_id_i,
  output logic [fsync_pkg::N_CUS-1:0]                          req_ready_o,

  // CU wakes.
  output logic [fsync_pkg::N_CUS-1:0]                          wake_o,
  output logic [fsync_pkg::N_CUS-1:0]                          wake_error_o,
  output logic [fsync_pkg::N_CUS-1:0][fsync_pkg::LVL_WIDTH-1:0] wake_level_o,
  output logic [fsync_pkg::N_CUS-1:0][ID_WIDTH-1:0]            wake_id_o
);

  // ****************************************
  // Links
  // ****************************************

  fsync_quad_if #(.ID_WIDTH(ID_WIDTH)) quad_if [fsync_pkg::N_QUADS] ();
  fsync_root_if #(.ID_WIDTH(ID_WIDTH)) root_if [fsync_pkg::N_QUADS] ();

  // ****************************************
  // CU ports
  // ****************************************

  fsync_cu_ports #(
    .ID_WIDTH (ID_WIDTH)
  ) i_cu_ports (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_level_i  (req_level_i),
    .req_id_i     (req_id_i),
    .req_ready_o  (req_ready_o),
    .wake_o       (wake_o),
    .wake_error_o (wake_error_o),
    .wake_level_o (wake_level_o),
    .wake_id_o    (wake_id_o),
    .quad_o       (quad_if)
  );

  // ****************************************
  // Quadrant nodes, level 1
  // ****************************************

  for (genvar q = 0; q < fsync_pkg::N_QUADS; q++) begin : gen_quad_node
    fsync_quad_node #(
      .ID_WIDTH (ID_WIDTH)
    ) i_quad_node (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .cu_i    (quad_if[q]),
      .root_o  (root_if[q])
    );
  end

  // ****************************************
  // Root node, level 2
  // ****************************************

  fsync_root_node #(
    .ID_WIDTH (ID_WIDTH)
  ) i_root_node (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .quad_i  (root_if)
  );

endmodule : fsync_net_4x4

// File: fsync_root_node.sv
// Root node of the barrier network.
// Level 2 barrier detection across the four quadrant nodes.

`timescale 1ns/1ps

module fsync_root_node #(
  parameter int unsigned ID_WIDTH = 4
) (
  input  logic           clk_i,
  input  logic           reset_i,
  fsync_root_if.root_side quad_i [fsync_pkg::N_QUADS]
);

  localparam int unsigned N_QUADS = fsync_pkg::N_QUADS;

  logic [N_QUADS-1:0]               up_valid;
  logic [N_QUADS-1:0][ID_WIDTH-1:0] up_id;
  logic                             ids_differ;
  logic                             fire;
  logic                             wake_q;
  logic                             err_q;
  logic                             fired_q;  // Blocks refire while up_valid is still held.

  // ****************************************
  // Quadrant collection
  // ****************************************

  for (genvar q = 0; q < N_QUADS; q++) begin : gen_quad
    assign up_valid[q]       = quad_i[q].up_valid;
    assign up_id[q]          = quad_i[q].up_id;
    assign quad_i[q].wake       = wake_q;
    assign quad_i[q].wake_error = err_q;
  end

  always_comb begin
    ids_differ = 1'b0;
    for (int q = 1; q < N_QUADS; q++) begin
      ids_differ |= (up_id[q] != up_id[0]);
    end
  end

  assign fire = (&up_valid) & ~fired_q;

  // ****************************************
  // Global wake
  // ****************************************

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wake_q  <= 1'b0;
      err_q   <= 1'b0;
      fired_q <= 1'b0;
    end else begin
      wake_q <= fire;
      err_q  <= fire & ids_differ;
      if (fire) begin
        fired_q <= 1'b1;
      end else if (up_valid == '0) begin
        fired_q <= 1'b0;  // All quadrants released.
      end
    end
  end

endmodule : fsync_root_node

// File: fsync_quad_node.sv
// Quadrant node of the barrier network.
// Level 1 barrier detection for four CUs, level 2 forwarding to the root
// and pass-through of the root wake.

`timescale 1ns/1ps

module fsync_quad_node #(
  parameter int unsigned ID_WIDTH = 4
) (
  input  logic           clk_i,
  input  logic           reset_i,
  fsync_quad_if.node_side cu_i,
  fsync_root_if.node_side root_o
);

  localparam int unsigned CUS_PER_QUAD = fsync_pkg::CUS_PER_QUAD;

  localparam logic [1:0] ST_IDLE       = 2'd0;
  localparam logic [1:0] ST_WAIT_ROOT  = 2'd1;  // Level 2 raised, root not yet fired.
  localparam logic [1:0] ST_WAIT_CLEAR = 2'd2;  // Fired, pending entries not yet gone.

  logic [1:0]          state_q;
  logic                wake_q;
  logic                err_q;
  logic                up_valid_q;
  logic [ID_WIDTH-1:0] up_id_q;

  logic all_pend;
  logic all_quad;
  logic all_global;
  logic ids_equal;

  // ****************************************
  // Member comparison
  // ****************************************

  always_comb begin
    all_quad   = 1'b1;
    all_global = 1'b1;
    ids_equal  = 1'b1;
    for (int m = 0; m < CUS_PER_QUAD; m++) begin
      all_quad   &= (cu_i.pend_level[m] == fsync_pkg::LVL_QUAD);
      all_global &= (cu_i.pend_level[m] == fsync_pkg::LVL_GLOBAL);
      ids_equal  &= (cu_i.pend_id[m] == cu_i.pend_id[0]);
    end
  end

  assign all_pend = &cu_i.pend_valid;

  // ****************************************
  // Barrier FSM
  // ****************************************

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= ST_IDLE;
      wake_q     <= 1'b0;
      err_q      <= 1'b0;
      up_valid_q <= 1'b0;
    end else begin
      wake_q <= 1'b0;  // Single-cycle pulse.
      case (state_q)
        ST_IDLE: begin
          if (all_pend) begin
            if (all_global && ids_equal) begin
              up_valid_q <= 1'b1;
              state_q    <= ST_WAIT_ROOT;
            end else begin
              // Quadrant barrier, or a level/id mismatch reported at once.
              wake_q  <= 1'b1;
              err_q   <= !(all_quad && ids_equal);
              state_q <= ST_WAIT_CLEAR;
            end
          end
        end
        ST_WAIT_ROOT: begin
          if (root_o.wake) begin
            up_valid_q <= 1'b0;
            state_q    <= ST_WAIT_CLEAR;
          end
        end
        default: begin
          if (cu_i.pend_valid == '0) state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Id travels with up_valid.
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && all_pend) up_id_q <= cu_i.pend_id[0];
  end

  assign root_o.up_valid = up_valid_q;
  assign root_o.up_id    = up_id_q;

  // Root wake goes straight down to the CU block.
  assign cu_i.wake       = wake_q | (state_q == ST_WAIT_ROOT && root_o.wake);
  assign cu_i.wake_error = (state_q == ST_WAIT_ROOT) ? root_o.wake_error : err_q;

endmodule : fsync_quad_node

// File: fsync_cu_ports.sv
// CU port block of the barrier network.
// Per-CU request acceptance and pending storage, CU to quadrant mapping,
// registered wake outputs.

`timescale 1ns/1ps

module fsync_cu_ports #(
  parameter int unsigned ID_WIDTH = 4
) (
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,
  input  logic [fsync_pkg::N_CUS-1:0]                          req_valid_i,
  input  logic [fsync_pkg::N_CUS-1:0][fsync_pkg::LVL_WIDTH-1:0] req_level_i,
  input  logic [fsync_pkg::N_CUS-1:0][ID_WIDTH-1:0]            req_id_i,
  output logic [fsync_pkg::N_CUS-1:0]                          req_ready_o,
  output logic [fsync_pkg::N_CUS-1:0]                          wake_o,
  output logic [fsync_pkg::N_CUS-1:0]                          wake_error_o,
  output logic [fsync_pkg::N_CUS-1:0][fsync_pkg::LVL_WIDTH-1:0] wake_level_o,
  output logic [fsync_pkg::N_CUS-1:0][ID_WIDTH-1:0]            wake_id_o,
  fsync_quad_if.cu_side                                        quad_o [fsync_pkg::N_QUADS]
);

  localparam int unsigned N_CUS         = fsync_pkg::N_CUS;
  localparam int unsigned LVL_WIDTH     = fsync_pkg::LVL_WIDTH;
  localparam int unsigned QUAD_DIM      = fsync_pkg::QUAD_DIM;
  localparam int unsigned QUADS_PER_ROW = fsync_pkg::GRID_DIM / QUAD_DIM;

  // ****************************************
  // Pending requests
  // ****************************************

  logic [N_CUS-1:0]                pend_valid_q;
  logic [N_CUS-1:0][LVL_WIDTH-1:0] pend_level_q;
  logic [N_CUS-1:0][ID_WIDTH-1:0]  pend_id_q;
  logic [N_CUS-1:0]                accept;
  logic [N_CUS-1:0]                cu_wake;  // Quadrant wake fanned out per CU.
  logic [N_CUS-1:0]                cu_err;

  assign req_ready_o = ~pend_valid_q;  // One outstanding request per CU.
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_valid_q <= '0;
      wake_o       <= '0;
      wake_error_o <= '0;
    end else begin
      wake_o       <= cu_wake;
      wake_error_o <= cu_wake & cu_err;
      // A wake only reaches pending CUs, an accept only idle ones.
      pend_valid_q <= (pend_valid_q | accept) & ~cu_wake;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int c = 0; c < N_CUS; c++) begin
      if (accept[c]) begin
        pend_level_q[c] <= req_level_i[c];
        pend_id_q[c]    <= req_id_i[c];
      end
    end
  end

  // Stored request stays put until the next accept, so it echoes with wake.
  assign wake_level_o = pend_level_q;
  assign wake_id_o    = pend_id_q;

  // ****************************************
  // Quadrant mapping
  // ****************************************

  for (genvar q = 0; q < fsync_pkg::N_QUADS; q++) begin : gen_quad
    localparam int unsigned QUAD_ROW = q / QUADS_PER_ROW;
    localparam int unsigned QUAD_COL = q % QUADS_PER_ROW;

    logic [fsync_pkg::CUS_PER_QUAD-1:0]                valid_m;
    logic [fsync_pkg::CUS_PER_QUAD-1:0][LVL_WIDTH-1:0] level_m;
    logic [fsync_pkg::CUS_PER_QUAD-1:0][ID_WIDTH-1:0]  id_m;

    for (genvar m = 0; m < fsync_pkg::CUS_PER_QUAD; m++) begin : gen_member
      // Member position inside the quadrant, then global row-major index.
      localparam int unsigned MEM_ROW    = m / QUAD_DIM;
      localparam int unsigned MEM_COL    = m % QUAD_DIM;
      localparam int unsigned ROW_OFFSET = (QUAD_ROW * QUAD_DIM + MEM_ROW) * fsync_pkg::GRID_DIM;
      localparam int unsigned COL_OFFSET = QUAD_COL * QUAD_DIM + MEM_COL;
      localparam int unsigned CU         = ROW_OFFSET + COL_OFFSET;

      assign valid_m[m]  = pend_valid_q[CU];
      assign level_m[m]  = pend_level_q[CU];
      assign id_m[m]     = pend_id_q[CU];
      assign cu_wake[CU] = quad_o[q].wake;
      assign cu_err[CU]  = quad_o[q].wake_error;
    end

    assign quad_o[q].pend_valid = valid_m;
    assign quad_o[q].pend_level = level_m;
    assign quad_o[q].pend_id    = id_m;
  end

endmodule : fsync_cu_ports

// File: fsync_root_if.sv
// Quadrant node to root node link.
// Level 2 request of one quadrant and the global wake pulse.

`timescale 1ns/1ps

interface fsync_root_if #(
  parameter int unsigned ID_WIDTH = 4
) ();

  logic                up_valid;  // Held until the root wakes.
  logic [ID_WIDTH-1:0] up_id;     // Common id of the quadrant.
  logic                wake;
  logic                wake_error;

  modport node_side (
    output up_valid, up_id,
    input  wake, wake_error
  );

  modport root_side (
    input  up_valid, up_id,
    output wake, wake_error
  );

endinterface : fsync_root_if

// File: fsync_quad_if.sv
// CU port block to quadrant node link.
// Registered pending state of four member CUs going up, wake pulse coming down.

`timescale 1ns/1ps

interface fsync_quad_if #(
  parameter int unsigned ID_WIDTH = 4
) ();

  // Pending state, one entry per member CU.
  logic [fsync_pkg::CUS_PER_QUAD-1:0]                           pend_valid;
  logic [fsync_pkg::CUS_PER_QUAD-1:0][fsync_pkg::LVL_WIDTH-1:0] pend_level;
  logic [fsync_pkg::CUS_PER_QUAD-1:0][ID_WIDTH-1:0]             pend_id;

  // Releases all four members.
  logic wake;
  logic wake_error;  // Valid with wake.

  modport cu_side (
    output pend_valid, pend_level, pend_id,
    input  wake, wake_error
  );

  modport node_side (
    input  pend_valid, pend_level, pend_id,
    output wake, wake_error
  );

endinterface : fsync_quad_if

// File: fsync_pkg.sv
// Barrier network package.
// Grid geometry of the 4x4 CU array and barrier level codes.

package fsync_pkg;

  // ****************************************
  // Grid geometry
  // ****************************************

  localparam int unsigned GRID_DIM     = 4;                    // CUs per grid side.
  localparam int unsigned N_CUS        = GRID_DIM * GRID_DIM;  // Row-major CU numbering.
  localparam int unsigned QUAD_DIM     = 2;                    // CUs per quadrant side.
  localparam int unsigned CUS_PER_QUAD = QUAD_DIM * QUAD_DIM;
  localparam int unsigned N_QUADS      = N_CUS / CUS_PER_QUAD;

  // ****************************************
  // Barrier levels
  // ****************************************

  localparam int unsigned LVL_WIDTH = 2;

  // Level 1 is served by a quadrant node, level 2 by the root.
  localparam logic [LVL_WIDTH-1:0] LVL_QUAD   = LVL_WIDTH'(1);
  localparam logic [LVL_WIDTH-1:0] LVL_GLOBAL = LVL_WIDTH'(2);

  // Codes 0 and 3 are not valid levels.

endpackage : fsync_pkg
